/* build.f */
source/memBusPkg.sv
source/memOpPkg.sv
source/memRequestFsm.sv
source/byteCounter.sv
source/byteAssembler.sv
source/ramPort.sv
source/memCtrl.sv
verif/memCtrl_properties.sv
verif/memCtrlTb.sv

/* source/byteAssembler.sv */
`timescale 1ns/1ps

module byteAssembler import memBusPkg::*, memOpPkg::*; #(
    parameter int wordWidth = memBusPkg::wordWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frozen,
    input  logic                 start,

    input  logic [1:0]           returnIdx,
    input  logic                 returnLast,
    input  lenCode               len,
    input  logic [ramWidth-1:0]  memDin,

    output logic [wordWidth-1:0] word
);

    laneWord held;
    laneWord merged;

    // lane 0 may catch a stray byte in the first cycle,
    // it gets overwritten when the real byte arrives
    always_ff @(posedge clk) begin
        if (rst || start) begin
            held <= '0;
        end else if (!frozen) begin
            held.lanes[returnIdx] <= memDin;
        end
    end

    always_comb begin
        merged = held;
        // final byte straight from the RAM so the word is ready with done
        if (returnLast) begin
            merged.lanes[returnIdx] = memDin;
        end
        // zero extension above the request length
        for (int i = 0; i < bytesPerWord; i++) begin
            if (i >= len) begin
                merged.lanes[i] = '0;
            end
        end
    end

    assign word = merged.whole;

endmodule

/* source/byteCounter.sv */
`timescale 1ns/1ps

module byteCounter import memOpPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       frozen,
    input  logic       start,
    input  reqKind     kind,
    input  lenCode     len,

    output logic [1:0] issueIdx,
    output logic       issueActive,
    output logic       storeLast,
    output logic       returnLast,
    output logic [1:0] returnIdx
);

    logic [2:0] issueCnt;
    logic [1:0] returnCnt;
    lenCode     effLen;
    logic       running;

    assign effLen  = (kind == reqFetch) ? fetchLen : len;
    assign running = (kind != reqIdle) && !start;

    assign issueActive = running && (issueCnt < effLen);
    assign storeLast   = (issueCnt == effLen - 3'd1);

    // last byte shows up one cycle after its address went out
    assign returnLast = running && (kind != reqStore) && (issueCnt == effLen);

    assign issueIdx  = issueCnt[1:0];
    assign returnIdx = returnCnt;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            issueCnt  <= '0;
            returnCnt <= '0;
        end else if (!frozen && running) begin
            if (issueActive) begin
                issueCnt <= issueCnt + 3'd1;
            end
            // returned index trails the issued one by a cycle
            returnCnt <= issueCnt[1:0];
        end
    end

endmodule

/* source/memBusPkg.sv */
package memBusPkg;

    // RAM side is one byte wide
    localparam int ramWidth = 8;

    // byte address and the word handed back to the clients
    localparam int addrWidth = 32;
    localparam int wordWidth = 32;

    localparam int bytesPerWord = 4;

    // assembly word, filled lane by lane as bytes return, read out whole
    typedef union packed {
        logic [bytesPerWord-1:0][ramWidth-1:0] lanes;
        logic [wordWidth-1:0]                  whole;
    } laneWord;

endpackage

/* source/memCtrl.sv */
`timescale 1ns/1ps

module memCtrl import memBusPkg::*, memOpPkg::*; #(
    parameter int addrWidth = memBusPkg::addrWidth,
    parameter int wordWidth = memBusPkg::wordWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rdy,
    input  logic                 ioBufferFull,

    input  logic [ramWidth-1:0]  memDin,
    output logic                 memRw,
    output logic [addrWidth-1:0] memAddr,
    output logic [ramWidth-1:0]  memDout,

    input  logic                 fetchEn,
    input  logic [addrWidth-1:0] fetchAddr,
    output logic                 fetchDone,
    output logic [wordWidth-1:0] fetchInst,

    input  logic                 dataEn,
    input  logic                 dataStore,
    input  lenCode               dataLen,
    input  logic [wordWidth-1:0] dataWdata,
    input  logic [addrWidth-1:0] dataAddr,
    output logic                 dataDone,
    output logic [wordWidth-1:0] dataRdata
);

    logic       frozen;
    reqKind     kind;
    logic       start;
    logic [1:0] issueIdx;
    logic       issueActive;
    logic       storeLast;
    logic       returnLast;
    logic [1:0] returnIdx;
    lenCode     len;
    laneWord    asmWord;

    // global stall, nothing moves
    assign frozen = !rdy || ioBufferFull;

    memRequestFsm fsm (
        .clk(clk), .rst(rst), .frozen(frozen),
        .fetchEn(fetchEn), .dataEn(dataEn), .dataStore(dataStore),
        .issueActive(issueActive), .returnLast(returnLast), .storeLast(storeLast),
        .kind(kind), .start(start), .fetchDone(fetchDone), .dataDone(dataDone)
    );

    byteCounter counter (
        .clk(clk), .rst(rst), .frozen(frozen), .start(start), .kind(kind), .len(len),
        .issueIdx(issueIdx), .issueActive(issueActive), .storeLast(storeLast),
        .returnLast(returnLast), .returnIdx(returnIdx)
    );

    ramPort #(.addrWidth(addrWidth), .wordWidth(wordWidth)) port (
        .clk(clk), .rst(rst), .frozen(frozen), .start(start), .kind(kind),
        .issueIdx(issueIdx), .issueActive(issueActive),
        .fetchAddr(fetchAddr), .dataAddr(dataAddr), .dataWdata(dataWdata),
        .dataLen(dataLen), .len(len),
        .memAddr(memAddr), .memDout(memDout), .memRw(memRw)
    );

    byteAssembler #(.wordWidth(wordWidth)) assembler (
        .clk(clk), .rst(rst), .frozen(frozen), .start(start),
        .returnIdx(returnIdx), .returnLast(returnLast), .len(len), .memDin(memDin),
        .word(asmWord)
    );

    // both clients see the same word, only their done tells whose it is
    assign fetchInst = asmWord.whole;
    assign dataRdata = asmWord.whole;

endmodule

/* source/memOpPkg.sv */
package memOpPkg;

    // what the controller is busy with
    typedef enum logic [1:0] {
        reqIdle,
        reqFetch,
        reqLoad,
        reqStore
    } reqKind;

    // number of bytes in a request, 1, 2 or 4
    typedef logic [2:0] lenCode;

    // instruction fetch always reads a full word
    localparam lenCode fetchLen = 3'd4;

endpackage

/* source/memRequestFsm.sv */
`timescale 1ns/1ps

module memRequestFsm import memOpPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   frozen,

    input  logic   fetchEn,
    input  logic   dataEn,
    input  logic   dataStore,

    input  logic   issueActive,
    input  logic   returnLast,
    input  logic   storeLast,

    output reqKind kind,
    output logic   start,
    output logic   fetchDone,
    output logic   dataDone
);

    reqKind state;
    reqKind pick;
    logic   readDone;
    logic   storeDone;

    // data side wins when both ask in the same cycle
    always_comb begin
        if (dataEn) begin
            pick = dataStore ? reqStore : reqLoad;
        end else if (fetchEn) begin
            pick = reqFetch;
        end else begin
            pick = reqIdle;
        end
    end

    // read ends once the last byte is back
    assign readDone  = returnLast;
    assign storeDone = storeLast && issueActive;

    assign start = !frozen && (state == reqIdle) && (pick != reqIdle);

    // while idle, show the chosen kind so the latches pick the right client
    always_comb begin
        if (frozen) begin
            kind = reqIdle;
        end else if (state == reqIdle) begin
            kind = pick;
        end else begin
            kind = state;
        end
    end

    assign fetchDone = !frozen && (state == reqFetch) && readDone;
    assign dataDone  = !frozen && (((state == reqLoad) && readDone) ||
                                   ((state == reqStore) && storeDone));

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= reqIdle;
        end else if (!frozen) begin
            case (state)
                reqIdle: begin
                    state <= pick;
                end
                reqFetch, reqLoad: begin
                    if (readDone) begin
                        state <= reqIdle;
                    end
                end
                reqStore: begin
                    if (storeDone) begin
                        state <= reqIdle;
                    end
                end
                default: begin
                    state <= reqIdle;
                end
            endcase
        end
    end

endmodule

/* source/ramPort.sv */
`timescale 1ns/1ps

module ramPort import memBusPkg::*, memOpPkg::*; #(
    parameter int addrWidth = memBusPkg::addrWidth,
    parameter int wordWidth = memBusPkg::wordWidth
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 frozen,
    input  logic                 start,
    input  reqKind               kind,
    input  logic [1:0]           issueIdx,
    input  logic                 issueActive,

    input  logic [addrWidth-1:0] fetchAddr,
    input  logic [addrWidth-1:0] dataAddr,
    input  logic [wordWidth-1:0] dataWdata,
    input  lenCode               dataLen,

    output lenCode               len,
    output logic [addrWidth-1:0] memAddr,
    output logic [ramWidth-1:0]  memDout,
    output logic                 memRw
);

    logic [addrWidth-1:0] base;
    logic [addrWidth-1:0] nextAddr;
    logic [addrWidth-1:0] lastAddr;
    logic [wordWidth-1:0] wdata;

    assign nextAddr = base + addrWidth'(issueIdx);

    always_ff @(posedge clk) begin
        if (start) begin
            base  <= (kind == reqFetch) ? fetchAddr : dataAddr;
            wdata <= dataWdata;
        end
        // remember what the RAM saw last, replayed while frozen
        if (!frozen) begin
            lastAddr <= nextAddr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            len <= '0;
        end else if (start) begin
            len <= (kind == reqFetch) ? fetchLen : dataLen;
        end
    end

    assign memAddr = frozen ? lastAddr : nextAddr;
    assign memDout = wdata[issueIdx*ramWidth +: ramWidth];
    assign memRw   = !frozen && (kind == reqStore) && issueActive;

endmodule

/* verif/memCtrlTb.sv */
`timescale 1ns/1ps

module memCtrlTb;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        ioBufferFull;
    logic [7:0]  memDin;
    logic        memRw;
    logic [31:0] memAddr;
    logic [7:0]  memDout;
    logic        fetchEn;
    logic [31:0] fetchAddr;
    logic        fetchDone;
    logic [31:0] fetchInst;
    logic        dataEn;
    logic        dataStore;
    logic [2:0]  dataLen;
    logic [31:0] dataWdata;
    logic [31:0] dataAddr;
    logic        dataDone;
    logic [31:0] dataRdata;

    logic [7:0] ram [256];
    logic [7:0] shadow [256];
    integer     seed;
    bit         freezeOn;
    bit         frozenNow;
    int         frozenCycles;

    memCtrl dut (.*);

    bind memCtrl memCtrlProperties #(.addrWidth(addrWidth)) props (
        .clk(clk), .rst(rst), .rdy(rdy), .ioBufferFull(ioBufferFull),
        .memRw(memRw), .memAddr(memAddr), .fetchDone(fetchDone), .dataDone(dataDone)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // byte wide synchronous RAM, read data one cycle after the address
    always @(posedge clk) begin
        if (memRw) begin
            ram[memAddr[7:0]] <= memDout;
        end
        memDin <= ram[memAddr[7:0]];
    end

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Errors found");
        $fatal(1, "run stopped");
    endtask

    always @(negedge clk) begin
        if (dut.props.failCount != 0) begin
            abortRun("protocol assertion failed");
        end
    end

    function automatic logic [7:0] randByte();
        return 8'($random(seed));
    endfunction

    // little endian word from the shadow, zero above len
    function automatic logic [31:0] expectWord(input logic [7:0] addr, input int len);
        logic [31:0] w;
        w = '0;
        for (int k = 0; k < len; k++) begin
            w[8*k +: 8] = shadow[8'(addr + k)];
        end
        return w;
    endfunction

    task automatic nextCycle();
        @(posedge clk);
        #1;
        if (freezeOn) begin
            rdy          = ($random(seed) % 4) != 0;
            ioBufferFull = ($random(seed) % 6) == 0;
        end else begin
            rdy          = 1'b1;
            ioBufferFull = 1'b0;
        end
        frozenNow = !rdy || ioBufferFull;
        if (frozenNow) begin
            frozenCycles++;
        end
    endtask

    task automatic checkQuiet(input string when);
        assert (!memRw && !fetchDone && !dataDone)
            else abortRun($sformatf("mismatch {memRw,fetchDone,dataDone} %s: got %h, expected 0",
                                    when, {memRw, fetchDone, dataDone}));
    endtask

    task automatic sendRequest(input bit wantFetch, input bit wantData, input bit store,
                               input logic [2:0] len, input logic [7:0] fa,
                               input logic [7:0] da, input logic [31:0] wd);
        frozenCycles = 0;
        nextCycle();
        fetchEn   = wantFetch;
        fetchAddr = {24'd0, fa};
        dataEn    = wantData;
        dataStore = store;
        dataLen   = len;
        dataAddr  = {24'd0, da};
        dataWdata = wd;
        if (wantData && store) begin
            for (int k = 0; k < len; k++) begin
                shadow[8'(da + k)] = wd[8*k +: 8];
            end
        end
    endtask

    // latency counts from the cycle the request went out, stalls add one each
    task automatic waitDone(input bit isFetch, input bit isRead, input int latency,
                            input logic [31:0] expected);
        int          cycles;
        logic [31:0] got;
        cycles = 0;
        do begin
            nextCycle();
            @(negedge clk);
            cycles++;
            assert (!(isFetch ? dataDone : fetchDone))
                else abortRun("done pulse came from the other client");
            if (cycles > 100) begin
                abortRun("timeout waiting for a done pulse");
            end
        end while (!(isFetch ? fetchDone : dataDone));
        assert (cycles == latency + frozenCycles)
            else abortRun($sformatf("done pulse came after %0d cycles, expected %0d",
                                    cycles, latency + frozenCycles));
        got = isFetch ? fetchInst : dataRdata;
        if (isRead) begin
            assert (got == expected)
                else abortRun($sformatf("mismatch %s: got %h, expected %h",
                                        isFetch ? "fetchInst" : "dataRdata", got, expected));
        end
    endtask

    task automatic doFetch(input logic [7:0] addr);
        sendRequest(1'b1, 1'b0, 1'b0, 3'd1, addr, 8'd0, 32'd0);
        waitDone(1'b1, 1'b1, 5, expectWord(addr, 4));
    endtask

    task automatic doLoad(input logic [2:0] len, input logic [7:0] addr);
        sendRequest(1'b0, 1'b1, 1'b0, len, 8'd0, addr, 32'd0);
        waitDone(1'b0, 1'b1, len + 1, expectWord(addr, len));
    endtask

    task automatic doStore(input logic [2:0] len, input logic [7:0] addr,
                           input logic [31:0] wd);
        sendRequest(1'b0, 1'b1, 1'b1, len, 8'd0, addr, wd);
        waitDone(1'b0, 1'b0, len, 32'd0);
        // read back with one neighbor on each side
        doLoad(3'd4, addr - 8'd1);
        doLoad(3'd4, addr + 8'd1);
    endtask

    task automatic doBoth(input bit store, input logic [2:0] len, input logic [7:0] fa,
                          input logic [7:0] da, input logic [31:0] wd);
        sendRequest(1'b1, 1'b1, store, len, fa, da, wd);
        waitDone(1'b0, !store, store ? len : len + 1, expectWord(da, len));
        // data side gone, fetch still waiting
        sendRequest(1'b1, 1'b0, 1'b0, len, fa, 8'd0, 32'd0);
        waitDone(1'b1, 1'b1, 5, expectWord(fa, 4));
    endtask

    initial begin
        seed         = 40340;
        freezeOn     = 1'b0;
        frozenCycles = 0;
        rst          = 1'b1;
        rdy          = 1'b1;
        ioBufferFull = 1'b0;
        memDin       = 8'd0;
        fetchEn      = 1'b0;
        fetchAddr    = 32'd0;
        dataEn       = 1'b0;
        dataStore    = 1'b0;
        dataLen      = 3'd1;
        dataWdata    = 32'd0;
        dataAddr     = 32'd0;
        for (int i = 0; i < 256; i++) begin
            ram[i]    = 8'(i * 7 + 8'h3c);
            shadow[i] = ram[i];
        end

        repeat (15) begin
            nextCycle();
            @(negedge clk);
            checkQuiet("during reset");
        end
        nextCycle();
        rst = 1'b0;
        repeat (3) begin
            nextCycle();
            @(negedge clk);
            checkQuiet("after reset");
        end

        // first pass runs without stalls, the later ones with random freeze
        for (int pass = 0; pass < 3; pass++) begin
            freezeOn = (pass != 0);
            repeat (3) begin
                doFetch(randByte());
            end
            for (int n = 1; n <= 4; n = n * 2) begin
                doLoad(3'(n), randByte());
                doStore(3'(n), randByte(), $random(seed));
                doBoth(1'b0, 3'(n), randByte(), randByte(), 32'd0);
                doBoth(1'b1, 3'(n), randByte(), randByte(), $random(seed));
            end
        end

        freezeOn = 1'b0;
        nextCycle();
        fetchEn = 1'b0;
        dataEn  = 1'b0;
        repeat (2) begin
            nextCycle();
        end
        for (int i = 0; i < 256; i++) begin
            assert (ram[i] == shadow[i])
                else abortRun($sformatf("mismatch ram[%h]: got %h, expected %h",
                                        i[7:0], ram[i], shadow[i]));
        end

        if (dut.props.failCount != 0) begin
            abortRun("protocol assertion failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* verif/memCtrl_properties.sv */
`timescale 1ns/1ps

module memCtrlProperties #(
    parameter int addrWidth = 32
) (
    input logic                 clk,
    input logic                 rst,
    input logic                 rdy,
    input logic                 ioBufferFull,
    input logic                 memRw,
    input logic [addrWidth-1:0] memAddr,
    input logic                 fetchDone,
    input logic                 dataDone
);

    int   failCount = 0;
    logic frozen;

    assign frozen = !rdy || ioBufferFull;

    // done strobes are single cycle pulses
    fetchPulse: assert property (@(posedge clk) disable iff (rst) fetchDone |=> !fetchDone)
        else begin
            $error("fetchDone held longer than one cycle");
            failCount++;
        end

    dataPulse: assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataDone)
        else begin
            $error("dataDone held longer than one cycle");
            failCount++;
        end

    oneClient: assert property (@(posedge clk) disable iff (rst) !(fetchDone && dataDone))
        else begin
            $error("fetchDone and dataDone high in the same cycle");
            failCount++;
        end

    // nothing moves during a stall
    quietFrozen: assert property (@(posedge clk) disable iff (rst)
                                  frozen |-> !memRw && !fetchDone && !dataDone)
        else begin
            $error("write or done seen while frozen");
            failCount++;
        end

    addrHeld: assert property (@(posedge clk) disable iff (rst) frozen |-> $stable(memAddr))
        else begin
            $error("memAddr moved while frozen");
            failCount++;
        end

    quietReset: assert property (@(posedge clk) rst |=> !memRw && !fetchDone && !dataDone)
        else begin
            $error("write or done seen right after a reset cycle");
            failCount++;
        end

endmodule
